// ==== ooo_issue_defs.svh ====
/*
 * sizing macros for the out-of-order issue subsystem
 * register file, data path, station depth, sequence index
 */

`ifndef OOO_ISSUE_DEFS_SVH
`define OOO_ISSUE_DEFS_SVH

// ======================================================================
// architectural state
// ======================================================================

// architectural registers
`define OOO_NUM_REGS 16
// register index width, log2 of the register count
`define OOO_REG_W 4
// data path width
`define OOO_DATA_W 16

// ======================================================================
// scheduling
// ======================================================================

// station entries, 2 or 8 also work
`define OOO_RS_SIZE 4
// sequence index width, wrap bit sits on top of it
`define OOO_SEQ_W 4

`endif

// ==== ooo_issue_pkg.sv ====
/*
 * shared types of the out-of-order issue subsystem
 * opcode enum, instruction word union, sequence tag, station entry
 */

`include "ooo_issue_defs.svh"

package ooo_issue_pkg;

  // register form ops first, immediate forms in the upper half
  typedef enum logic [3:0] {
    OP_ADD  = 4'h0,
    OP_SUB  = 4'h1,
    OP_AND  = 4'h2,
    OP_XOR  = 4'h3,
    OP_ADDI = 4'h8,
    OP_LUI  = 4'h9
  } opcode_e;

  // register form: rd = rs1 op rs2
  typedef struct packed {
    opcode_e               opcode;
    logic [`OOO_REG_W-1:0] rd;
    logic [`OOO_REG_W-1:0] rs1;
    logic [`OOO_REG_W-1:0] rs2;
  } inst_reg_t;

  // immediate form, addi reads rd as its source
  typedef struct packed {
    opcode_e               opcode;
    logic [`OOO_REG_W-1:0] rd;
    logic [7:0]            imm;
  } inst_imm_t;

  // same 16 bits, two views
  typedef union packed {
    inst_reg_t r;
    inst_imm_t i;
  } inst_word_u;

  // program order tag
  typedef struct packed {
    logic                  wrap;
    logic [`OOO_SEQ_W-1:0] idx;
  } seq_t;

  // one source operand, value or waiting tag
  typedef struct packed {
    logic                   rdy;
    logic [`OOO_REG_W-1:0]  tag;
    logic [`OOO_DATA_W-1:0] val;
  } src_t;

  typedef struct packed {
    logic                  valid;
    opcode_e               opcode;
    logic [`OOO_REG_W-1:0] rd;
    src_t                  src_a;
    src_t                  src_b;
    seq_t                  seq;
  } rs_entry_t;

  // legal ops write rd, anything else is a silent no-op
  function automatic logic op_writes(input opcode_e op);
    return op inside {OP_ADD, OP_SUB, OP_AND, OP_XOR, OP_ADDI, OP_LUI};
  endfunction

endpackage

// ==== ooo_issue_if.sv ====
/*
 * internal buses of the issue subsystem
 * dispatch (decoder to station), issue (station to ALU),
 * wakeup (result broadcast to every listener)
 */

`timescale 1ns/1ps
`include "ooo_issue_defs.svh"

interface dispatch_if;
  import ooo_issue_pkg::*;
  logic      valid;
  rs_entry_t entry;
  logic      full;
  modport master  (output valid, entry, input full);
  modport station (input valid, entry, output full);
endinterface

interface issue_if;
  import ooo_issue_pkg::*;
  logic                   valid;
  opcode_e                opcode;
  logic [`OOO_REG_W-1:0]  rd;
  logic [`OOO_DATA_W-1:0] opnd_a;
  logic [`OOO_DATA_W-1:0] opnd_b;
  seq_t                   seq;
  modport source (output valid, opcode, rd, opnd_a, opnd_b, seq);
  modport sink   (input valid, opcode, rd, opnd_a, opnd_b, seq);
endinterface

interface wake_if;
  import ooo_issue_pkg::*;
  logic                   valid;
  logic [`OOO_REG_W-1:0]  rd;
  logic [`OOO_DATA_W-1:0] data;
  seq_t                   seq;
  modport driver   (output valid, rd, data, seq);
  modport listener (input valid, rd, data, seq);
  modport monitor  (input valid, rd, data, seq);
endinterface

// ==== inst_decoder.sv ====
/*
 * decode stage
 * splits the instruction word, reads operands with result bypass,
 * numbers accepted instructions and stalls on full station or busy rd
 */

`timescale 1ns/1ps
`include "ooo_issue_defs.svh"

module inst_decoder (
  input  logic                                        clk,
  input  logic                                        rst_n,
  input  logic                                        flush_i,
  input  logic                                        inst_valid_i,
  input  ooo_issue_pkg::inst_word_u                   inst_i,
  output logic                                        inst_ready_o,
  input  logic [`OOO_NUM_REGS-1:0]                    busy_i,
  input  logic [`OOO_NUM_REGS-1:0][`OOO_DATA_W-1:0]   rf_data_i,
  dispatch_if.master                                  disp,
  wake_if.listener                                    wake
);
  import ooo_issue_pkg::*;

  opcode_e               op;
  logic                  is_imm;
  logic                  writes;
  logic                  need_a;
  logic                  need_b;
  logic                  dest_busy;
  logic [`OOO_REG_W-1:0] tag_a;
  src_t                  src_a;
  src_t                  src_b;
  seq_t                  seq_q;

  // operand lookup: free register, same-cycle broadcast, else wait on tag
  function automatic src_t read_src(input logic need, input logic [`OOO_REG_W-1:0] tag);
    src_t s;
    s.tag = need ? tag : '0;
    s.rdy = 1'b1;
    s.val = '0;
    if (need) begin
      if (!busy_i[tag]) begin
        s.val = rf_data_i[tag];
      end else if (wake.valid && wake.rd == tag) begin
        // bypass, the register file write lands at this same edge
        s.val = wake.data;
      end else begin
        s.rdy = 1'b0;
      end
    end
    return s;
  endfunction

  // ====================================================================
  // field decode
  // ====================================================================

  always_comb begin
    op     = inst_i.r.opcode;
    is_imm = op inside {OP_ADDI, OP_LUI};
    writes = op_writes(op);
    // lui has no register source, illegal ops have none at all
    need_a = writes && (op != OP_LUI);
    need_b = writes && !is_imm;
    tag_a  = is_imm ? inst_i.i.rd : inst_i.r.rs1;
    src_a  = read_src(need_a, tag_a);
    src_b  = read_src(need_b, inst_i.r.rs2);
    // raw immediate rides in operand b, the ALU extends it
    if (is_imm) begin
      src_b.val = `OOO_DATA_W'(inst_i.i.imm);
    end
  end

  // waw hazard, no renaming so hold until rd is free
  assign dest_busy    = writes && busy_i[inst_i.r.rd];
  assign inst_ready_o = !disp.full && !dest_busy && !flush_i;

  assign disp.valid = inst_valid_i && inst_ready_o;
  assign disp.entry = '{valid:  1'b1,
                        opcode: op,
                        rd:     inst_i.r.rd,
                        src_a:  src_a,
                        src_b:  src_b,
                        seq:    seq_q};

  // ====================================================================
  // sequence counter
  // ====================================================================

  // {wrap, idx} counts as one word, so wrap flips on index rollover
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      seq_q <= '0;
    end else if (disp.valid) begin
      seq_q <= seq_t'(seq_q + 1'b1);
    end
  end

endmodule

// ==== reservation_station.sv ====
/*
 * non-compacting reservation station
 * lowest-free-slot write, broadcast wakeup, oldest-ready issue
 */

`timescale 1ns/1ps
`include "ooo_issue_defs.svh"

module reservation_station (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        flush_i,
  dispatch_if.station disp,
  wake_if.listener    wake,
  issue_if.source     iss
);
  import ooo_issue_pkg::*;

  localparam int IDX_W = (`OOO_RS_SIZE > 1) ? $clog2(`OOO_RS_SIZE) : 1;

  rs_entry_t [`OOO_RS_SIZE-1:0] mem_q;
  rs_entry_t [`OOO_RS_SIZE-1:0] mem_d;

  logic [`OOO_RS_SIZE-1:0] free;
  logic [`OOO_RS_SIZE-1:0] ready;
  logic [IDX_W-1:0]        wr_idx;
  logic [IDX_W-1:0]        sel_idx;
  logic                    sel_vld;
  seq_t                    sel_seq;

  // x older than y, wrap-aware
  function automatic logic is_older(input seq_t x, input seq_t y);
    if (x.wrap == y.wrap) begin
      return x.idx < y.idx;
    end
    // wrap differs so the larger index was handed out first
    return x.idx > y.idx;
  endfunction

  // capture a matching broadcast into a waiting source
  function automatic src_t snoop(input src_t s);
    src_t r;
    r = s;
    if (wake.valid && !s.rdy && s.tag == wake.rd) begin
      r.rdy = 1'b1;
      r.val = wake.data;
    end
    return r;
  endfunction

  // ====================================================================
  // slot status and write pointer
  // ====================================================================

  always_comb begin
    wr_idx = '0;
    for (int j = 0; j < `OOO_RS_SIZE; j++) begin
      free[j]  = !mem_q[j].valid;
      ready[j] = mem_q[j].valid && mem_q[j].src_a.rdy && mem_q[j].src_b.rdy;
    end
    // walk down so the lowest free slot wins
    for (int j = `OOO_RS_SIZE - 1; j >= 0; j--) begin
      if (free[j]) begin
        wr_idx = IDX_W'(j);
      end
    end
  end

  assign disp.full = ~|free;

  // ====================================================================
  // oldest-ready select
  // ====================================================================

  always_comb begin
    sel_vld = 1'b0;
    sel_idx = '0;
    sel_seq = '0;
    for (int j = 0; j < `OOO_RS_SIZE; j++) begin
      if (ready[j] && (!sel_vld || is_older(mem_q[j].seq, sel_seq))) begin
        sel_vld = 1'b1;
        sel_idx = IDX_W'(j);
        sel_seq = mem_q[j].seq;
      end
    end
  end

  // plain strobe, ALU takes it every cycle
  assign iss.valid  = sel_vld;
  assign iss.opcode = mem_q[sel_idx].opcode;
  assign iss.rd     = mem_q[sel_idx].rd;
  assign iss.opnd_a = mem_q[sel_idx].src_a.val;
  assign iss.opnd_b = mem_q[sel_idx].src_b.val;
  assign iss.seq    = mem_q[sel_idx].seq;

  // ====================================================================
  // next state
  // ====================================================================

  always_comb begin
    mem_d = mem_q;
    // wakeup on every slot, idle slots are don't-care
    for (int j = 0; j < `OOO_RS_SIZE; j++) begin
      mem_d[j].src_a = snoop(mem_q[j].src_a);
      mem_d[j].src_b = snoop(mem_q[j].src_b);
    end
    // issued slot frees at this edge
    if (sel_vld) begin
      mem_d[sel_idx].valid = 1'b0;
    end
    // new entry goes to a free slot, never the one issuing
    if (disp.valid) begin
      mem_d[wr_idx] = disp.entry;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mem_q <= '0;
    end else if (flush_i) begin
      for (int j = 0; j < `OOO_RS_SIZE; j++) begin
        mem_q[j].valid <= 1'b0;
      end
    end else begin
      mem_q <= mem_d;
    end
  end

  // decoder only offers while a slot is free
  a_no_write_full: assert property (@(posedge clk) disable iff (!rst_n)
    disp.valid |-> !disp.full);

endmodule

// ==== alu_exec.sv ====
/*
 * single-cycle integer ALU
 * add, sub, and, xor, addi, lui with a registered result broadcast
 */

`timescale 1ns/1ps
`include "ooo_issue_defs.svh"

module alu_exec (
  input  logic   clk,
  input  logic   rst_n,
  input  logic   flush_i,
  issue_if.sink  iss,
  wake_if.driver wake
);
  import ooo_issue_pkg::*;

  logic [`OOO_DATA_W-1:0] res;
  logic [`OOO_DATA_W-1:0] imm_sext;

  // immediate arrives zero-extended in the low byte of operand b
  assign imm_sext = {{(`OOO_DATA_W - 8){iss.opnd_b[7]}}, iss.opnd_b[7:0]};

  // ====================================================================
  // compute
  // ====================================================================

  always_comb begin
    case (iss.opcode)
      OP_ADD:  res = iss.opnd_a + iss.opnd_b;
      OP_SUB:  res = iss.opnd_a - iss.opnd_b;
      OP_AND:  res = iss.opnd_a & iss.opnd_b;
      OP_XOR:  res = iss.opnd_a ^ iss.opnd_b;
      OP_ADDI: res = iss.opnd_a + imm_sext;
      // upper byte load, low bits cleared
      OP_LUI:  res = {iss.opnd_b[7:0], {(`OOO_DATA_W - 8){1'b0}}};
      default: res = '0;
    endcase
  end

  // ====================================================================
  // result register
  // ====================================================================

  // illegal ops leave the station here without a broadcast
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wake.valid <= 1'b0;
    end else if (flush_i) begin
      wake.valid <= 1'b0;
    end else begin
      wake.valid <= iss.valid && op_writes(iss.opcode);
    end
  end

  always_ff @(posedge clk) begin
    if (iss.valid) begin
      wake.rd   <= iss.rd;
      wake.data <= res;
      wake.seq  <= iss.seq;
    end
  end

  // operands of an issued op were all captured as values
  a_issue_known: assert property (@(posedge clk) disable iff (!rst_n)
    iss.valid |-> !$isunknown({iss.opnd_a, iss.opnd_b}));

endmodule

// ==== result_writeback.sv ====
/*
 * result stage
 * architectural register file and busy bits,
 * written and cleared from the result broadcast
 */

`timescale 1ns/1ps
`include "ooo_issue_defs.svh"

module result_writeback (
  input  logic                                      clk,
  input  logic                                      rst_n,
  input  logic                                      flush_i,
  wake_if.monitor                                   wake,
  input  logic [`OOO_NUM_REGS-1:0]                  set_busy_i,
  output logic [`OOO_NUM_REGS-1:0]                  busy_o,
  output logic [`OOO_NUM_REGS-1:0][`OOO_DATA_W-1:0] rf_data_o
);

  logic [`OOO_NUM_REGS-1:0][`OOO_DATA_W-1:0] rf_q;
  logic [`OOO_NUM_REGS-1:0]                  busy_q;
  logic [`OOO_NUM_REGS-1:0]                  clr_busy;

  // ====================================================================
  // register file
  // ====================================================================

  // a write in the flush cycle still lands, it was already broadcast
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rf_q <= '0;
    end else if (wake.valid) begin
      rf_q[wake.rd] <= wake.data;
    end
  end

  // ====================================================================
  // busy bits
  // ====================================================================

  always_comb begin
    clr_busy = '0;
    if (wake.valid) begin
      clr_busy[wake.rd] = 1'b1;
    end
  end

  // set and clear never hit the same register, dispatch waits on busy rd
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q <= '0;
    end else if (flush_i) begin
      busy_q <= '0;
    end else begin
      busy_q <= (busy_q & ~clr_busy) | set_busy_i;
    end
  end

  assign busy_o    = busy_q;
  assign rf_data_o = rf_q;

  // every result was announced by a dispatch that marked rd busy
  a_wake_busy: assert property (@(posedge clk) disable iff (!rst_n)
    wake.valid |-> busy_q[wake.rd]);

endmodule

// ==== ooo_issue_top.sv ====
/*
 * top level of the out-of-order issue subsystem
 * decoder, reservation station, ALU and result stage on internal buses
 */

`timescale 1ns/1ps
`include "ooo_issue_defs.svh"

module ooo_issue_top (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      flush_i,
  input  logic                      inst_valid_i,
  input  ooo_issue_pkg::inst_word_u inst_i,
  output logic                      inst_ready_o,
  output logic                      result_valid_o,
  output logic [`OOO_REG_W-1:0]     result_rd_o,
  output logic [`OOO_DATA_W-1:0]    result_data_o,
  output ooo_issue_pkg::seq_t       result_seq_o
);
  import ooo_issue_pkg::*;

  logic [`OOO_NUM_REGS-1:0]                  busy;
  logic [`OOO_NUM_REGS-1:0]                  set_busy;
  logic [`OOO_NUM_REGS-1:0][`OOO_DATA_W-1:0] rf_data;

  dispatch_if disp_bus ();
  issue_if    iss_bus ();
  wake_if     wake_bus ();

  // accepted legal op claims its rd, one-hot
  always_comb begin
    set_busy = '0;
    if (disp_bus.valid && op_writes(disp_bus.entry.opcode)) begin
      set_busy[disp_bus.entry.rd] = 1'b1;
    end
  end

  inst_decoder inst_decoder_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .flush_i      (flush_i),
    .inst_valid_i (inst_valid_i),
    .inst_i       (inst_i),
    .inst_ready_o (inst_ready_o),
    .busy_i       (busy),
    .rf_data_i    (rf_data),
    .disp         (disp_bus.master),
    .wake         (wake_bus.listener)
  );

  reservation_station reservation_station_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .flush_i (flush_i),
    .disp    (disp_bus.station),
    .wake    (wake_bus.listener),
    .iss     (iss_bus.source)
  );

  alu_exec alu_exec_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .flush_i (flush_i),
    .iss     (iss_bus.sink),
    .wake    (wake_bus.driver)
  );

  result_writeback result_writeback_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .flush_i    (flush_i),
    .wake       (wake_bus.monitor),
    .set_busy_i (set_busy),
    .busy_o     (busy),
    .rf_data_o  (rf_data)
  );

  // result broadcast out to the ports
  assign result_valid_o = wake_bus.valid;
  assign result_rd_o    = wake_bus.rd;
  assign result_data_o  = wake_bus.data;
  assign result_seq_o   = wake_bus.seq;

endmodule

// ==== tb_ooo_issue.sv ====
/*
 * testbench for the out-of-order issue subsystem
 * in-order reference model, result table by sequence number,
 * directed tests for dispatch, wakeup, oldest-ready issue, flush
 */

`timescale 1ns/1ps
`include "ooo_issue_defs.svh"

module tb_ooo_issue;
  import ooo_issue_pkg::*;

  localparam int SEQ_N    = 1 << (`OOO_SEQ_W + 1);
  localparam int WAIT_MAX = 50;
  localparam int DRAIN_MAX = 100;

  logic                   clk;
  logic                   rst_n;
  logic                   flush;
  logic                   inst_valid;
  inst_word_u             inst;
  logic                   inst_ready;
  logic                   res_valid;
  logic [`OOO_REG_W-1:0]  res_rd;
  logic [`OOO_DATA_W-1:0] res_data;
  seq_t                   res_seq;

  // reference state, updated in program order at accept
  logic [`OOO_NUM_REGS-1:0][`OOO_DATA_W-1:0] ref_rf;
  seq_t                   model_seq;
  logic [SEQ_N-1:0]       pending;
  logic [`OOO_REG_W-1:0]  exp_rd [SEQ_N];
  logic [`OOO_DATA_W-1:0] exp_data [SEQ_N];
  int                     outstanding;
  seq_t                   done_q [$];
  seq_t                   last_seq;
  int                     last_stalls;

  ooo_issue_top ooo_issue_top_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .flush_i        (flush),
    .inst_valid_i   (inst_valid),
    .inst_i         (inst),
    .inst_ready_o   (inst_ready),
    .result_valid_o (res_valid),
    .result_rd_o    (res_rd),
    .result_data_o  (res_data),
    .result_seq_o   (res_seq)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // ======================================================================
  // failure reporting and compares
  // ======================================================================

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("TB FAILED");
    $fatal(1);
  endtask

  task automatic check_data(input string name, input logic [`OOO_DATA_W-1:0] got,
                            input logic [`OOO_DATA_W-1:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("Error at %0t: %s = %h, expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_reg(input string name, input logic [`OOO_REG_W-1:0] got,
                           input logic [`OOO_REG_W-1:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("Error at %0t: %s = %h, expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_seq(input string name, input seq_t got, input seq_t exp);
    if (got !== exp) begin
      fail_run($sformatf("Error at %0t: %s = %h, expected %h", $time, name, got, exp));
    end
  endtask

  // ======================================================================
  // reference model
  // ======================================================================

  function automatic inst_word_u reg_op(input opcode_e op, input logic [`OOO_REG_W-1:0] rd,
                                        input logic [`OOO_REG_W-1:0] rs1,
                                        input logic [`OOO_REG_W-1:0] rs2);
    inst_word_u w;
    w.r = '{op, rd, rs1, rs2};
    return w;
  endfunction

  function automatic inst_word_u imm_op(input opcode_e op, input logic [`OOO_REG_W-1:0] rd,
                                        input logic [7:0] imm);
    inst_word_u w;
    w.i = '{op, rd, imm};
    return w;
  endfunction

  // addi reads its own rd, lui loads the high byte
  function automatic logic [`OOO_DATA_W-1:0] model_result(input inst_word_u w);
    logic [`OOO_DATA_W-1:0] a;
    logic [`OOO_DATA_W-1:0] b;
    a = ref_rf[w.r.rs1];
    b = ref_rf[w.r.rs2];
    case (w.r.opcode)
      OP_ADD:  return a + b;
      OP_SUB:  return a - b;
      OP_AND:  return a & b;
      OP_XOR:  return a ^ b;
      OP_ADDI: return ref_rf[w.i.rd] + {{(`OOO_DATA_W - 8){w.i.imm[7]}}, w.i.imm};
      OP_LUI:  return {w.i.imm, {(`OOO_DATA_W - 8){1'b0}}};
      default: return '0;
    endcase
  endfunction

  // results sampled mid-cycle, matched by sequence number
  always @(negedge clk) begin
    int k;
    if (rst_n && res_valid) begin
      k = res_seq;
      if (!pending[k]) begin
        fail_run("a result appeared for a sequence number with nothing pending");
      end
      check_reg("result_rd_o", res_rd, exp_rd[k]);
      check_data("result_data_o", res_data, exp_data[k]);
      pending[k] = 1'b0;
      outstanding--;
      done_q.push_back(res_seq);
    end
  end

  // ======================================================================
  // drivers
  // ======================================================================

  // offer one instruction, hold until accepted, log it in the model
  task automatic send(input inst_word_u w);
    int k;
    inst       = w;
    inst_valid = 1'b1;
    last_stalls = 0;
    @(negedge clk);
    while (!inst_ready) begin
      last_stalls++;
      if (last_stalls > WAIT_MAX) begin
        fail_run("timeout waiting for inst_ready_o to accept an instruction");
      end
      @(negedge clk);
    end
    k = model_seq;
    if (pending[k]) begin
      fail_run("sequence table overrun, an old result never arrived");
    end
    exp_rd[k]   = w.r.rd;
    exp_data[k] = model_result(w);
    pending[k]  = 1'b1;
    outstanding++;
    ref_rf[w.r.rd] = exp_data[k];
    last_seq  = model_seq;
    model_seq = seq_t'(model_seq + 1'b1);
    @(posedge clk);
    #10;
    inst_valid = 1'b0;
  endtask

  task automatic drain();
    int n;
    n = 0;
    while (outstanding != 0) begin
      n++;
      if (n > DRAIN_MAX) begin
        fail_run("timeout waiting for pending results to drain");
      end
      @(posedge clk);
    end
    #10;
  endtask

  // one-cycle flush, then forget the squashed instruction
  task automatic flush_and_cancel(input seq_t s);
    flush = 1'b1;
    @(posedge clk);
    #10;
    flush = 1'b0;
    pending[s] = 1'b0;
    outstanding--;
  endtask

  // ======================================================================
  // directed tests
  // ======================================================================

  task automatic test_reset_basic();
    if (inst_ready !== 1'b1) begin
      fail_run("inst_ready_o is not high after reset");
    end
    if (res_valid !== 1'b0) begin
      fail_run("result_valid_o is not low after reset");
    end
    done_q.delete();
    send(imm_op(OP_LUI, 1, 8'h12));
    send(imm_op(OP_ADDI, 2, 8'h85));
    drain();
    if (done_q.size() != 2) begin
      fail_run("LUI and ADDI did not give exactly two results");
    end
    check_seq("result_seq_o", done_q[0], seq_t'(0));
    check_seq("result_seq_o", done_q[1], seq_t'(1));
  endtask

  // add feeds sub feeds xor, back to back
  task automatic test_dep_chain();
    send(imm_op(OP_ADDI, 3, 8'h3c));
    send(reg_op(OP_ADD, 4, 1, 3));
    send(reg_op(OP_SUB, 5, 4, 2));
    send(reg_op(OP_XOR, 6, 5, 4));
    drain();
  endtask

  // lui overtakes the sub stuck behind a two-deep chain
  task automatic test_out_of_order();
    seq_t s [4];
    done_q.delete();
    send(imm_op(OP_ADDI, 7, 8'h05));
    s[0] = last_seq;
    send(reg_op(OP_ADD, 8, 7, 7));
    s[1] = last_seq;
    send(reg_op(OP_SUB, 9, 8, 1));
    s[2] = last_seq;
    send(imm_op(OP_LUI, 10, 8'ha5));
    s[3] = last_seq;
    drain();
    if (done_q.size() != 4) begin
      fail_run("out-of-order test did not give exactly four results");
    end
    check_seq("result_seq_o", done_q[0], s[0]);
    check_seq("result_seq_o", done_q[1], s[1]);
    check_seq("result_seq_o", done_q[2], s[3]);
    check_seq("result_seq_o", done_q[3], s[2]);
  endtask

  task automatic test_stall();
    int   total;
    seq_t first;
    // waw on r11
    send(imm_op(OP_ADDI, 11, 8'h11));
    send(imm_op(OP_ADDI, 11, 8'h22));
    if (last_stalls == 0) begin
      fail_run("inst_ready_o stayed high with a busy destination");
    end
    drain();
    done_q.delete();
    // long chain so its consumers pile up in the station
    send(imm_op(OP_ADDI, 12, 8'h09));
    first = last_seq;
    send(reg_op(OP_ADD, 13, 12, 12));
    send(reg_op(OP_ADD, 14, 13, 13));
    send(reg_op(OP_ADD, 15, 14, 14));
    total = 0;
    for (int j = 0; j <= `OOO_RS_SIZE; j++) begin
      send(reg_op(opcode_e'(j % 4), `OOO_REG_W'(j + 1), 15, 6));
      total += last_stalls;
    end
    if (total == 0) begin
      fail_run("inst_ready_o stayed high while the station was full");
    end
    drain();
    // consumers wake on r15 together so oldest-first keeps program order
    if (done_q.size() != `OOO_RS_SIZE + 5) begin
      fail_run("station fill test did not give one result per instruction");
    end
    for (int j = 0; j < `OOO_RS_SIZE + 5; j++) begin
      check_seq("result_seq_o", done_q[j], seq_t'(first + j));
    end
  endtask

  task automatic test_flush();
    logic [`OOO_NUM_REGS-1:0][`OOO_DATA_W-1:0] saved;
    saved = ref_rf;
    send(imm_op(OP_ADDI, 3, 8'h7f));
    flush_and_cancel(last_seq);
    ref_rf = saved;
    // producer finishes in the flush cycle, its consumer is squashed
    send(imm_op(OP_ADDI, 4, 8'h01));
    saved = ref_rf;
    send(reg_op(OP_ADD, 5, 4, 4));
    flush_and_cancel(last_seq);
    ref_rf = saved;
    drain();
    repeat (4) @(posedge clk);
    #10;
    send(reg_op(OP_ADD, 7, 3, 5));
    send(reg_op(OP_SUB, 8, 4, 5));
    send(imm_op(OP_ADDI, 3, 8'h02));
    drain();
  endtask

  task automatic test_random();
    inst_word_u            w;
    logic [`OOO_REG_W-1:0] rd;
    logic [`OOO_REG_W-1:0] ra;
    logic [`OOO_REG_W-1:0] rb;
    logic [7:0]            imm;
    for (int n = 0; n < 40; n++) begin
      rd  = $urandom;
      ra  = $urandom;
      rb  = $urandom;
      imm = $urandom;
      case ($urandom % 6)
        0:       w = reg_op(OP_ADD, rd, ra, rb);
        1:       w = reg_op(OP_SUB, rd, ra, rb);
        2:       w = reg_op(OP_AND, rd, ra, rb);
        3:       w = reg_op(OP_XOR, rd, ra, rb);
        4:       w = imm_op(OP_ADDI, rd, imm);
        default: w = imm_op(OP_LUI, rd, imm);
      endcase
      send(w);
    end
    drain();
  endtask

  // ======================================================================
  // run
  // ======================================================================

  initial begin
    void'($urandom(32'h766cd756));
    rst_n       = 1'b0;
    flush       = 1'b0;
    inst_valid  = 1'b0;
    inst        = '0;
    ref_rf      = '0;
    model_seq   = '0;
    pending     = '0;
    outstanding = 0;
    repeat (4) @(posedge clk);
    #10;
    rst_n = 1'b1;
    test_reset_basic();
    test_dep_chain();
    test_out_of_order();
    test_stall();
    test_flush();
    test_random();
    $display("TB PASSED");
    $finish;
  end

endmodule

// ==== ooo_issue_top.f ====
+incdir+.
ooo_issue_pkg.sv
ooo_issue_if.sv
inst_decoder.sv
reservation_station.sv
alu_exec.sv
result_writeback.sv
ooo_issue_top.sv
tb_ooo_issue.sv

// ==== Bender.yml ====
package:
  name: ooo_issue

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - ooo_issue_pkg.sv
      - ooo_issue_if.sv
      - inst_decoder.sv
      - reservation_station.sv
      - alu_exec.sv
      - result_writeback.sv
      - ooo_issue_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_ooo_issue.sv
